// ==== include/cpu_consts.svh ====
// widths, reset values and fixed encodings of the core, included by the package and the RTL
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data path and address width
`define XLEN 64

// instruction word width
`define ILEN 32

// register index width and register count
`define REG_ADDR_W 5
`define REG_COUNT 32

// program counter right after reset
`define RESET_PC 64'h0000_0000_0000_0000

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

// sequential pc increment, one 32-bit instruction
`define PC_STEP 64'd4

`endif

// ==== source/cpu_pkg.sv ====
// shared types of the core: the major opcodes and the packets passed between stages
`include "cpu_consts.svh"

package cpu_pkg;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_OP_IMM = 7'b0010011, // addi and friends
        OPC_OP     = 7'b0110011, // register-register alu
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // instruction register as seen by the execute stage
    typedef struct packed {
        logic [`ILEN-1:0] instr; // raw instruction word
        logic [`XLEN-1:0] pc;    // address it was fetched from
        logic             valid; // low in the slot after a taken redirect
    } fetch_pkt_t;

    // decoder output
    typedef struct packed {
        opcode_e                opcode;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [2:0]             funct3;
        logic                   sub_bit; // funct7[5], selects sub over add
        logic [`XLEN-1:0]       imm;     // sign extended, chosen per format
        logic                   known;   // opcode is one of opcode_e
    } decoded_t;

    // data memory request, read data comes back in the same cycle
    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
        logic             we;    // write on the next rising edge
    } mem_req_t;

    // control transfer from execute back to fetch
    typedef struct packed {
        logic             taken;
        logic [`XLEN-1:0] target;
    } redirect_t;

endpackage

// ==== source/fetch_stage.sv ====
// fetch stage: pc register, instruction register and the one-slot bubble after a redirect
`timescale 1ns/100ps
`include "cpu_consts.svh"

module fetch_stage (
    input  logic                  clk_1hz,
    input  logic                  reset_n,
    input  cpu_pkg::redirect_t    redirect,   // from execute, combinational
    input  logic [`ILEN-1:0]      i_mem_data, // same-cycle answer for i_mem_addr
    output logic [`XLEN-1:0]      i_mem_addr,
    output cpu_pkg::fetch_pkt_t   fetch_pkt
);

    logic [`XLEN-1:0] pc;      // address presented to instruction memory
    logic [`XLEN-1:0] next_pc;
    logic             squash;  // word fetched now lands in a dead slot

    // redirect wins over the sequential step
    always_comb begin
        if (redirect.taken) begin
            next_pc = redirect.target;
        end else begin
            next_pc = pc + `PC_STEP;
        end
    end

    // the instruction fetched alongside a taken redirect is the wrong path
    assign squash = redirect.taken;

    assign i_mem_addr = pc; // plain combinational read, no request strobe

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            pc <= `RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    // instruction register plus its pc, valid drops for exactly one slot
    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            fetch_pkt.instr <= `NOP_INSTR; // execute sees a harmless addi first
            fetch_pkt.pc    <= `RESET_PC;
            fetch_pkt.valid <= 1'b1;
        end else begin
            fetch_pkt.instr <= i_mem_data;
            fetch_pkt.pc    <= pc;         // pc of the word just latched
            fetch_pkt.valid <= !squash;
        end
    end

endmodule

// ==== source/instr_decoder.sv ====
// combinational decoder: splits the instruction register into fields and one sign-extended immediate
`timescale 1ns/100ps
`include "cpu_consts.svh"

module instr_decoder (
    input  cpu_pkg::fetch_pkt_t     fetch_pkt,
    output cpu_pkg::decoded_t       decoded,
    output logic [`REG_ADDR_W-1:0]  rs1_addr, // straight to the register file
    output logic [`REG_ADDR_W-1:0]  rs2_addr
);

    import cpu_pkg::*;

    logic [`ILEN-1:0] ir;
    logic [6:0]       op_bits;
    logic [`XLEN-1:0] imm_i; // addi, ld
    logic [`XLEN-1:0] imm_s; // sd
    logic [`XLEN-1:0] imm_b; // beq, bne
    logic [`XLEN-1:0] imm_u; // lui, auipc
    logic [`XLEN-1:0] imm_j; // jal
    logic             known;

    assign ir      = fetch_pkt.instr;
    assign op_bits = ir[6:0];

    // immediates, all sign extended from ir[31]
    assign imm_i = {{(`XLEN-12){ir[31]}}, ir[31:20]};
    assign imm_s = {{(`XLEN-12){ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b = {{(`XLEN-13){ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {{(`XLEN-32){ir[31]}}, ir[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    // anything outside the enum executes as a no-op downstream
    always_comb begin
        case (op_bits)
            OPC_LUI,
            OPC_AUIPC,
            OPC_OP_IMM,
            OPC_OP,
            OPC_LOAD,
            OPC_STORE,
            OPC_BRANCH,
            OPC_JAL: known = 1'b1;
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        decoded.opcode  = opcode_e'(op_bits);
        decoded.rd      = ir[11:7];
        decoded.rs1     = ir[19:15];
        decoded.rs2     = ir[24:20];
        decoded.funct3  = ir[14:12];
        decoded.sub_bit = ir[30]; // funct7 = 0100000 for sub
        decoded.known   = known;

        // immediate format follows the opcode
        case (op_bits)
            OPC_OP_IMM,
            OPC_LOAD:   decoded.imm = imm_i;
            OPC_STORE:  decoded.imm = imm_s;
            OPC_BRANCH: decoded.imm = imm_b;
            OPC_LUI,
            OPC_AUIPC:  decoded.imm = imm_u;
            OPC_JAL:    decoded.imm = imm_j;
            default:    decoded.imm = '0; // r-type and unknown
        endcase
    end

    assign rs1_addr = ir[19:15];
    assign rs2_addr = ir[24:20];

endmodule

// ==== source/reg_file.sv ====
// general register file, two combinational read ports and one write port, x0 reads as zero
`timescale 1ns/100ps
`include "cpu_consts.svh"

module reg_file (
    input  logic                   clk_1hz,
    input  logic                   reset_n,
    input  logic [`REG_ADDR_W-1:0] rs1_addr,
    input  logic [`REG_ADDR_W-1:0] rs2_addr,
    input  logic [`REG_ADDR_W-1:0] wr_addr,
    input  logic                   wr_en,
    input  logic [`XLEN-1:0]       wr_data,
    output logic [`XLEN-1:0]       rs1_data,
    output logic [`XLEN-1:0]       rs2_data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic             wr_live; // write strobe with x0 filtered out

    // only place where writes to x0 are dropped
    assign wr_live = wr_en && (wr_addr != '0);

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0; // software expects a clean file after reset
            end
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // reads see the old value during a write, new value next cycle
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== source/execute_unit.sv ====
// execute stage: alu, branch compare, jal link, load/store addressing and write-back control
`timescale 1ns/100ps
`include "cpu_consts.svh"

module execute_unit (
    input  cpu_pkg::fetch_pkt_t     fetch_pkt,
    input  cpu_pkg::decoded_t       decoded,
    input  logic [`XLEN-1:0]        rs1_data,
    input  logic [`XLEN-1:0]        rs2_data,
    input  logic [`XLEN-1:0]        mem_data_in, // same-cycle load data
    output logic                    wr_en,
    output logic [`REG_ADDR_W-1:0]  wr_addr,
    output logic [`XLEN-1:0]        wr_data,
    output cpu_pkg::mem_req_t       mem_req,
    output cpu_pkg::redirect_t      redirect
);

    import cpu_pkg::*;

    logic             live;     // valid slot and a recognised opcode
    logic [`XLEN-1:0] sum_imm;  // rs1 + imm, addi and ld/sd address
    logic [`XLEN-1:0] pc_imm;   // pc + imm, auipc and branch/jal target
    logic [`XLEN-1:0] link;     // return address for jal
    logic [`XLEN-1:0] add_sub;
    logic             eq;
    logic             f3_zero;  // funct3 000: addi, add/sub, beq
    logic             f3_dword; // funct3 011: ld, sd

    assign live     = fetch_pkt.valid && decoded.known; // bubble slot does nothing
    assign sum_imm  = rs1_data + decoded.imm;
    assign pc_imm   = fetch_pkt.pc + decoded.imm;
    assign link     = fetch_pkt.pc + `PC_STEP;
    assign add_sub  = decoded.sub_bit ? (rs1_data - rs2_data) : (rs1_data + rs2_data);
    assign eq       = (rs1_data == rs2_data);
    assign f3_zero  = (decoded.funct3 == 3'b000);
    assign f3_dword = (decoded.funct3 == 3'b011);

    assign wr_addr = decoded.rd; // x0 filtering is in the register file

    always_comb begin
        // defaults: no write, no store, no redirect
        wr_en           = 1'b0;
        wr_data         = sum_imm;
        mem_req.addr    = sum_imm;   // decoder already picked the i or s immediate
        mem_req.wdata   = rs2_data;
        mem_req.we      = 1'b0;
        redirect.taken  = 1'b0;
        redirect.target = pc_imm;

        case (decoded.opcode)
            OPC_LUI: begin
                wr_en   = live;
                wr_data = decoded.imm;
            end
            OPC_AUIPC: begin
                wr_en   = live;
                wr_data = pc_imm;
            end
            OPC_OP_IMM: begin
                wr_en   = live && f3_zero; // addi only, other funct3 are no-ops
                wr_data = sum_imm;
            end
            OPC_OP: begin
                wr_en   = live && f3_zero; // add / sub
                wr_data = add_sub;
            end
            OPC_LOAD: begin
                wr_en   = live && f3_dword; // ld, memory answers this cycle
                wr_data = mem_data_in;
            end
            OPC_STORE: begin
                mem_req.we = live && f3_dword; // sd
            end
            OPC_BRANCH: begin
                case (decoded.funct3)
                    3'b000:  redirect.taken = live && eq;  // beq
                    3'b001:  redirect.taken = live && !eq; // bne
                    default: redirect.taken = 1'b0;
                endcase
            end
            OPC_JAL: begin
                wr_en          = live;
                wr_data        = link;
                redirect.taken = live; // always costs one squashed slot
            end
            default: begin
                wr_en = 1'b0; // unknown opcode, no effect
            end
        endcase
    end

endmodule

// ==== source/cpu_top.sv ====
// top of the two-stage core, memories sit outside and answer in the same cycle
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpu_top (
    input  logic                clk_1hz,
    input  logic                reset_n,
    output logic [`XLEN-1:0]    i_mem_addr,  // instruction fetch address
    input  logic [`ILEN-1:0]    i_mem_data,
    output cpu_pkg::mem_req_t   mem_req,     // data load/store request
    input  logic [`XLEN-1:0]    mem_data_in
);

    import cpu_pkg::*;

    fetch_pkt_t             fetch_pkt;
    decoded_t               decoded;
    redirect_t              redirect;  // execute back to fetch
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`REG_ADDR_W-1:0] wr_addr;
    logic                   wr_en;
    logic [`XLEN-1:0]       wr_data;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;

    // stage 1
    fetch_stage fetch_i (
        .clk_1hz    (clk_1hz),
        .reset_n    (reset_n),
        .redirect   (redirect),
        .i_mem_data (i_mem_data),
        .i_mem_addr (i_mem_addr),
        .fetch_pkt  (fetch_pkt)
    );

    // stage 2, decode and register read feed execute in the same cycle
    instr_decoder decoder_i (
        .fetch_pkt (fetch_pkt),
        .decoded   (decoded),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr)
    );

    reg_file regs_i (
        .clk_1hz  (clk_1hz),
        .reset_n  (reset_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wr_addr  (wr_addr),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    execute_unit execute_i (
        .fetch_pkt   (fetch_pkt),
        .decoded     (decoded),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .mem_data_in (mem_data_in),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .mem_req     (mem_req),
        .redirect    (redirect)
    );

endmodule

// ==== tests/cpu_chk.sv ====
// assertion checker bound into cpu_top, watches fetch addresses, redirects and data stores
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpu_chk (
    input logic               clk_1hz,
    input logic               reset_n,
    input logic [`XLEN-1:0]   i_mem_addr,
    input cpu_pkg::mem_req_t  mem_req,
    input cpu_pkg::redirect_t redirect  // internal execute to fetch path
);

    int fail_count = 0; // read by the testbench at the end of the run

    // fetch addresses stay on 4-byte boundaries
    fetch_aligned: assert property (@(posedge clk_1hz) i_mem_addr[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("fetch address %h is not word aligned", i_mem_addr);
        end

    // first cycle out of reset executes the reset nop, so no store
    no_store_after_reset: assert property (@(posedge clk_1hz) $rose(reset_n) |-> !mem_req.we)
        else begin
            fail_count++;
            $error("store request in the first cycle after reset release");
        end

    // sequential fetch steps by one instruction
    pc_steps: assert property (@(posedge clk_1hz)
        (reset_n && $past(reset_n) && !$past(redirect.taken))
            |-> i_mem_addr == $past(i_mem_addr) + 64'd4)
        else begin
            fail_count++;
            $error("fetch address %h did not advance by 4", i_mem_addr);
        end

    // slot after a taken redirect is squashed
    no_store_in_bubble: assert property (@(posedge clk_1hz)
        (reset_n && $past(reset_n) && $past(redirect.taken)) |-> !mem_req.we)
        else begin
            fail_count++;
            $error("store issued from the squashed slot, address %h", mem_req.addr);
        end

endmodule

bind cpu_top cpu_chk chk_i (
    .clk_1hz    (clk_1hz),
    .reset_n    (reset_n),
    .i_mem_addr (i_mem_addr),
    .mem_req    (mem_req),
    .redirect   (redirect)
);

// ==== tests/cpu_tb.sv ====
// directed testbench for cpu_top, holds both memories and runs short programs ending in stores
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpu_tb;

    import cpu_pkg::*;

    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_load  = 7'b0000011;

    logic             clk_1hz;
    logic             reset_n;
    logic [`XLEN-1:0] i_mem_addr;
    logic [`ILEN-1:0] i_mem_data;
    mem_req_t         mem_req;
    logic [`XLEN-1:0] mem_data_in;

    logic [`ILEN-1:0] imem [256]; // word indexed, 1 KiB of code
    logic [`XLEN-1:0] dmem [256]; // doubleword indexed, 2 KiB of data
    integer           seed;
    int               mismatches;
    int               timeouts;

    cpu_top dut_i (
        .clk_1hz     (clk_1hz),
        .reset_n     (reset_n),
        .i_mem_addr  (i_mem_addr),
        .i_mem_data  (i_mem_data),
        .mem_req     (mem_req),
        .mem_data_in (mem_data_in)
    );

    initial begin
        clk_1hz = 1'b0;
        forever #10 clk_1hz = ~clk_1hz; // 20 ns period
    end

    // outside the array the fetch sees nops
    assign i_mem_data  = (i_mem_addr[`XLEN-1:10] == '0) ? imem[i_mem_addr[9:2]] : `NOP_INSTR;
    assign mem_data_in = dmem[mem_req.addr[10:3]];

    // store lands at the rising edge that ends the sd cycle
    always @(posedge clk_1hz) begin
        if (mem_req.we) begin
            dmem[mem_req.addr[10:3]] = mem_req.wdata;
        end
    end

    function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        return {f7, rs2, rs1, 3'b000, rd, 7'b0110011}; // add or sub
    endfunction

    function automatic logic [31:0] s_type(input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011}; // sd
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [63:0] sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    // lui/auipc immediate as it lands in a 64-bit register
    function automatic logic [63:0] upper20(input logic [19:0] v);
        return {{32{v[19]}}, v, 12'b0};
    endfunction

    function automatic logic [63:0] fill_word(input int idx);
        return {32'hc0de_0000 ^ 32'(idx), ~32'(idx)}; // every index gives its own word
    endfunction

    task automatic clear_memories();
        for (int i = 0; i < 256; i++) begin
            imem[i] = `NOP_INSTR;
            dmem[i] = fill_word(i);
        end
    endtask

    task automatic pulse_reset();
        reset_n = 1'b0; // callers sit on a falling edge
        repeat (3) @(negedge clk_1hz);
        reset_n = 1'b1;
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    // wait for a store to addr, sampled mid-cycle where the request is stable
    task automatic expect_store(input string name, input logic [63:0] addr,
                                input logic [63:0] expected);
        bit seen;
        logic [63:0] data;
        seen = 1'b0;
        data = '0;
        for (int n = 0; n < 40 && !seen; n++) begin
            @(negedge clk_1hz);
            if (mem_req.we && mem_req.addr == addr) begin
                seen = 1'b1;
                data = mem_req.wdata;
            end
        end
        if (!seen) begin
            timeouts++;
            $display("timeout: no store to address %h within 40 cycles (%s)", addr, name);
        end else begin
            check_value(name, expected, data);
        end
    endtask

    task automatic lui_addi_test();
        logic [31:0] rnd;
        rnd = $random(seed);
        clear_memories();
        imem[0] = u_type(op_lui, 5'd1, rnd[31:12]);
        imem[1] = i_type(op_imm, 3'b000, 5'd1, 5'd1, rnd[11:0]);
        imem[2] = s_type(5'd0, 5'd1, 12'h100);
        pulse_reset();
        expect_store("mem_req.wdata lui+addi", 64'h100, upper20(rnd[31:12]) + sext12(rnd[11:0]));
    endtask

    task automatic add_sub_test();
        logic [31:0] a;
        logic [31:0] b;
        a = $random(seed);
        b = $random(seed);
        clear_memories();
        imem[0] = i_type(op_imm, 3'b000, 5'd1, 5'd0, a[11:0]);
        imem[1] = i_type(op_imm, 3'b000, 5'd2, 5'd0, b[11:0]);
        imem[2] = r_type(7'b0000000, 5'd3, 5'd1, 5'd2); // add x3
        imem[3] = r_type(7'b0100000, 5'd4, 5'd1, 5'd2); // sub x4
        imem[4] = s_type(5'd0, 5'd3, 12'h110);
        imem[5] = s_type(5'd0, 5'd4, 12'h118);
        pulse_reset();
        expect_store("mem_req.wdata add", 64'h110, sext12(a[11:0]) + sext12(b[11:0]));
        expect_store("mem_req.wdata sub", 64'h118, sext12(a[11:0]) - sext12(b[11:0]));
    endtask

    task automatic load_add_test();
        logic [31:0] hi;
        logic [31:0] lo;
        logic [31:0] imm;
        hi = $random(seed);
        lo = $random(seed);
        imm = $random(seed);
        clear_memories();
        dmem[64] = {hi, lo}; // address 0x200
        imem[0] = i_type(op_load, 3'b011, 5'd1, 5'd0, 12'h200);
        imem[1] = i_type(op_imm, 3'b000, 5'd1, 5'd1, imm[11:0]);
        imem[2] = s_type(5'd0, 5'd1, 12'h208);
        pulse_reset();
        expect_store("mem_req.wdata ld+addi", 64'h208, {hi, lo} + sext12(imm[11:0]));
    endtask

    task automatic branch_test();
        logic [31:0] r;
        r = $random(seed);
        clear_memories();
        imem[0]  = i_type(op_imm, 3'b000, 5'd1, 5'd0, r[11:0]);
        imem[1]  = i_type(op_imm, 3'b000, 5'd2, 5'd0, r[11:0]);
        imem[2]  = b_type(3'b000, 5'd1, 5'd2, 13'd12); // beq to 0x14
        imem[3]  = s_type(5'd0, 5'd1, 12'h180);        // marker, must not store
        imem[4]  = s_type(5'd0, 5'd1, 12'h180);
        imem[5]  = s_type(5'd0, 5'd1, 12'h188);
        imem[6]  = i_type(op_imm, 3'b000, 5'd3, 5'd1, 12'd1);
        imem[7]  = b_type(3'b001, 5'd1, 5'd3, 13'd12); // bne to 0x28
        imem[8]  = s_type(5'd0, 5'd3, 12'h190);
        imem[9]  = s_type(5'd0, 5'd3, 12'h190);
        imem[10] = s_type(5'd0, 5'd3, 12'h198);
        pulse_reset();
        expect_store("mem_req.wdata beq target", 64'h188, sext12(r[11:0]));
        expect_store("mem_req.wdata bne target", 64'h198, sext12(r[11:0]) + 64'd1);
        check_value("dmem[0x180] beq marker", fill_word(48), dmem[48]);
        check_value("dmem[0x190] bne marker", fill_word(50), dmem[50]);
    endtask

    task automatic jal_auipc_test();
        logic [31:0] r;
        r = $random(seed);
        clear_memories();
        imem[2] = j_type(5'd5, 21'd16);         // jal at 0x8 to 0x18
        imem[3] = s_type(5'd0, 5'd5, 12'h1b0);  // skipped path
        imem[4] = s_type(5'd0, 5'd5, 12'h1b0);
        imem[5] = s_type(5'd0, 5'd5, 12'h1b0);
        imem[6] = s_type(5'd0, 5'd5, 12'h1a0);
        imem[7] = u_type(op_auipc, 5'd6, r[19:0]); // auipc at 0x1c
        imem[8] = s_type(5'd0, 5'd6, 12'h1a8);
        pulse_reset();
        expect_store("mem_req.wdata jal link", 64'h1a0, 64'd12);
        expect_store("mem_req.wdata auipc", 64'h1a8, 64'd28 + upper20(r[19:0]));
        check_value("dmem[0x1b0] jal marker", fill_word(54), dmem[54]);
    endtask

    task automatic zero_reg_test();
        logic [31:0] r;
        r = $random(seed);
        clear_memories();
        imem[0] = i_type(op_imm, 3'b000, 5'd0, 5'd0, r[11:0] | 12'd1); // write to x0 dropped
        imem[1] = s_type(5'd0, 5'd0, 12'h1c0);
        pulse_reset();
        expect_store("mem_req.wdata x0", 64'h1c0, 64'd0);
    endtask

    initial begin
        seed = 50;
        reset_n = 1'b0;
        mismatches = 0;
        timeouts = 0;
        clear_memories();
        @(negedge clk_1hz); // first reset pulse starts on a falling edge too
        lui_addi_test();
        add_sub_test();
        load_add_test();
        branch_test();
        jal_auipc_test();
        zero_reg_test();
        @(negedge clk_1hz);
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, dut_i.chk_i.fail_count);
        if (mismatches == 0 && timeouts == 0 && dut_i.chk_i.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+include
source/cpu_pkg.sv
source/fetch_stage.sv
source/instr_decoder.sv
source/reg_file.sv
source/execute_unit.sv
source/cpu_top.sv
tests/cpu_chk.sv
tests/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the core and its testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/100ps -f all.f --top-module cpu_tb \
    -o cpu_sim &&
./obj_dir/cpu_sim +verilator+error+limit+100 | tee /dev/stderr |
    grep -F '** PASS **' > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
